/* logic/power_pkg.sv */
/*
 * Power sequencer definitions
 * Rail count, rail indices, timer widths, FSM state codes and the rail word view
 */
`default_nettype none

package power_pkg;

	localparam int rail_count = 15;
	localparam int rail_idx_bits = 4;
	localparam int last_rail = rail_count - 1;

	// A count ends when the counter's top bit sets
	localparam int delay_bits_default = 17;
	localparam int watchdog_bits_default = 24;

	// Rails feeding the second socket
	localparam logic [rail_count-1:0] cpub_rail_mask = 15'h5548;

	// Sequencer states
	localparam int state_bits = 3;
	localparam logic [state_bits-1:0] st_off = 3'd0;
	localparam logic [state_bits-1:0] st_wait = 3'd1;
	localparam logic [state_bits-1:0] st_settle = 3'd2;
	localparam logic [state_bits-1:0] st_on = 3'd3;
	localparam logic [state_bits-1:0] st_fault = 3'd4;

	// One rail word seen as a bitmap or as two register bytes
	typedef union packed {
		struct packed {
			logic spare;
			logic [rail_count-1:0] rails;
		} map;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} halves;
	} rail_word_u;

endpackage

`default_nettype wire

/* logic/reg_pkg.sv */
/*
 * Status register map
 * Byte addresses, identification values and status bit positions
 */
`default_nettype none

package reg_pkg;

	localparam logic [7:0] version_addr = 8'd0;
	localparam logic [7:0] clr_err_addr = 8'd3;
	localparam logic [7:0] pg_snap_hi_addr = 8'd5;
	localparam logic [7:0] pg_snap_lo_addr = 8'd6;
	localparam logic [7:0] status_addr = 8'd7;
	localparam logic [7:0] en_lo_addr = 8'd8;
	localparam logic [7:0] en_hi_addr = 8'd9;
	localparam logic [7:0] pg_lo_addr = 8'd10;
	localparam logic [7:0] pg_hi_addr = 8'd11;
	localparam logic [7:0] vendor_addr = 8'd12;

	localparam logic [7:0] fpga_version = 8'h06;
	localparam logic [7:0] vendor_id0 = 8'h52;
	localparam logic [7:0] vendor_id1 = 8'h43;
	localparam logic [7:0] vendor_id2 = 8'h53;
	localparam logic [7:0] vendor_id3 = 8'h20;

	// Status byte layout
	localparam int stat_sysgood_bit = 0;
	localparam int stat_sysen_bit = 1;
	localparam int stat_fault_bit = 2;
	localparam int stat_op_err_bit = 3;
	localparam int stat_wait_err_bit = 4;
	localparam int stat_cpub_bit = 5;

endpackage

`default_nettype wire

/* logic/rail_conditioner.sv */
/*
 * Rail conditioner
 * Masks second-socket enables, fakes their power-good when the CPU is absent,
 * applies the debug override and synchronizes power-good and system enable
 */
`default_nettype none

module rail_conditioner (
	input wire logic clk_in,
	input wire logic reset,
	input wire logic sysen,
	input wire logic debug_in,
	input wire logic cpub_present_n,
	input wire logic [power_pkg::rail_count-1:0] rail_pg,
	input wire logic [power_pkg::rail_count-1:0] en_req,
	output logic [power_pkg::rail_count-1:0] rail_en,
	output logic [power_pkg::rail_count-1:0] pg_sync,
	output logic sysen_sync,
	output logic cpub_clk_oe
);
	import power_pkg::*;

	logic [rail_count-1:0] absent_mask;
	logic [rail_count-1:0] pg_cond;
	logic [rail_count-1:0] pg_meta;
	logic sysen_cond;
	logic sysen_meta;

	// Second-socket rails while that CPU is missing
	assign absent_mask = cpub_rail_mask & {rail_count{cpub_present_n}};

	always_ff @(posedge clk_in) begin
		if (reset) begin
			rail_en <= '0;
			cpub_clk_oe <= 1'b0;
			pg_cond <= '0;
			pg_meta <= '0;
			pg_sync <= '0;
			sysen_cond <= 1'b0;
			sysen_meta <= 1'b0;
			sysen_sync <= 1'b0;
		end else begin
			rail_en <= en_req & ~absent_mask;
			cpub_clk_oe <= ~cpub_present_n;
			// Absent rails report good as soon as they are requested
			pg_cond <= rail_pg | (absent_mask & en_req);
			// Debug strap low forces the system on
			sysen_cond <= sysen | ~debug_in;
			pg_meta <= pg_cond;
			pg_sync <= pg_meta;
			sysen_meta <= sysen_cond;
			sysen_sync <= sysen_meta;
		end
	end

	// No second-socket rail is driven while the CPU is absent
	assert property (@(posedge clk_in) disable iff (reset)
		cpub_present_n |=> ((rail_en & cpub_rail_mask) == '0));

endmodule

`default_nettype wire

/* logic/seq_timer.sv */
/*
 * Sequencer timers
 * Settle delay after each power-good and watchdog between enable and power-good
 */
`default_nettype none

module seq_timer #(
	parameter int delay_bits = power_pkg::delay_bits_default,
	parameter int watchdog_bits = power_pkg::watchdog_bits_default
) (
	input wire logic clk_in,
	input wire logic reset,
	input wire logic delay_run,
	input wire logic wait_run,
	output logic delay_done_pulse,
	output logic wait_expired
);

	logic [delay_bits-1:0] delay_cnt;
	logic [watchdog_bits-1:0] wait_cnt;

	always_ff @(posedge clk_in) begin
		if (reset) begin
			delay_cnt <= '0;
			wait_cnt <= '0;
			delay_done_pulse <= 1'b0;
			wait_expired <= 1'b0;
		end else begin
			delay_done_pulse <= delay_run & delay_cnt[delay_bits-1];
			wait_expired <= wait_run & wait_cnt[watchdog_bits-1];

			// Each counter restarts when its run level drops or its count ends
			if (!delay_run || delay_cnt[delay_bits-1]) begin
				delay_cnt <= '0;
			end else begin
				delay_cnt <= delay_cnt + 1'b1;
			end
			if (!wait_run || wait_cnt[watchdog_bits-1]) begin
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// The FSM never waits and settles at once
	assert property (@(posedge clk_in) disable iff (reset) !(delay_run && wait_run));

endmodule

`default_nettype wire

/* logic/sequencer_fsm.sv */
/*
 * Rail sequencer FSM
 * Walks the rails in order, generates the enable requests,
 * latches watchdog and operation faults and produces sysgood
 */
`default_nettype none

module sequencer_fsm (
	input wire logic clk_in,
	input wire logic reset,
	input wire logic [power_pkg::rail_count-1:0] pg_sync,
	input wire logic sysen_sync,
	input wire logic delay_done_pulse,
	input wire logic wait_expired,
	input wire logic clr_err,
	input wire logic bmc_software_pg,
	output logic delay_run,
	output logic wait_run,
	output logic [power_pkg::rail_count-1:0] en_req,
	output logic [power_pkg::rail_count-1:0] settled,
	output logic fault,
	output logic op_err,
	output logic wait_err,
	output logic sysgood_raw,
	output logic sysgood
);
	import power_pkg::*;

	logic [state_bits-1:0] state;
	logic [rail_idx_bits-1:0] rail_idx;
	logic [rail_count-1:0] en_next;
	logic op_detect;
	logic wait_timeout;
	logic fault_next;

	assign wait_run = (state == st_wait);
	assign delay_run = (state == st_settle);
	assign sysgood_raw = (state == st_on);
	assign fault = (state == st_fault);

	// Settled rail that has lost its power-good
	assign op_detect = |(settled & ~pg_sync);
	assign wait_timeout = wait_run & wait_expired;
	assign fault_next = fault ? ~clr_err : (op_detect | wait_timeout);

	// Up behind the rail below, down only after the rail above is gone
	always_comb begin
		en_next[0] = sysen_sync | pg_sync[1];
		for (int i = 1; i < last_rail; i++) begin
			en_next[i] = (sysen_sync & settled[i-1]) | pg_sync[i+1];
		end
		en_next[last_rail] = sysen_sync & settled[last_rail-1];
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			state <= st_off;
			rail_idx <= '0;
			settled <= '0;
			en_req <= '0;
			op_err <= 1'b0;
			wait_err <= 1'b0;
			sysgood <= 1'b0;
		end else begin
			en_req <= fault_next ? '0 : en_next;
			sysgood <= sysgood_raw & bmc_software_pg;

			if (fault) begin
				if (clr_err) begin
					state <= st_off;
					op_err <= 1'b0;
					wait_err <= 1'b0;
				end
			end else if (op_detect || wait_timeout) begin
				state <= st_fault;
				settled <= '0;
				op_err <= op_detect;
				wait_err <= wait_timeout;
			end else if (!sysen_sync) begin
				// Power-down runs from the enable rule alone
				state <= st_off;
				settled <= '0;
			end else begin
				case (state)
					st_off: begin
						rail_idx <= '0;
						state <= st_wait;
					end
					st_wait: begin
						if (pg_sync[rail_idx]) begin
							state <= st_settle;
						end
					end
					st_settle: begin
						if (delay_done_pulse) begin
							settled[rail_idx] <= 1'b1;
							if (rail_idx == rail_idx_bits'(last_rail)) begin
								state <= st_on;
							end else begin
								rail_idx <= rail_idx + 1'b1;
								state <= st_wait;
							end
						end
					end
					st_on: begin
						state <= st_on;
					end
					default: begin
						state <= st_off;
					end
				endcase
			end
		end
	end

	// Every rail stays dark for as long as the fault is held
	assert property (@(posedge clk_in) disable iff (reset) fault |-> (en_req == '0));

endmodule

`default_nettype wire

/* logic/status_regs.sv */
/*
 * Status registers
 * Byte-wide register file behind the bus slave strobes,
 * with the error-clear read and a power-good snapshot frozen on fault
 */
`default_nettype none

module status_regs (
	input wire logic clk_in,
	input wire logic reset,
	input wire logic read_req,
	input wire logic data_valid,
	input wire logic [7:0] data_from_master,
	input wire power_pkg::rail_word_u pg_sync,
	input wire power_pkg::rail_word_u rail_en,
	input wire logic [power_pkg::rail_count-1:0] settled,
	input wire logic fault,
	input wire logic op_err,
	input wire logic wait_err,
	input wire logic sysgood_raw,
	input wire logic sysen_sync,
	input wire logic cpub_present_n,
	output logic [7:0] data_to_master,
	output logic clr_err
);
	import power_pkg::*;
	import reg_pkg::*;

	logic [7:0] reg_ptr;
	logic load_pending;
	logic [7:0] status_byte;
	logic [7:0] read_byte;
	rail_word_u pg_snap;

	always_comb begin
		status_byte = '0;
		status_byte[stat_sysgood_bit] = sysgood_raw;
		status_byte[stat_sysen_bit] = sysen_sync;
		status_byte[stat_fault_bit] = fault;
		status_byte[stat_op_err_bit] = op_err;
		status_byte[stat_wait_err_bit] = wait_err;
		status_byte[stat_cpub_bit] = ~cpub_present_n;
	end

	always_comb begin
		case (reg_ptr)
			version_addr: read_byte = fpga_version;
			clr_err_addr: read_byte = 8'hff;
			pg_snap_hi_addr: read_byte = pg_snap.halves.hi;
			pg_snap_lo_addr: read_byte = pg_snap.halves.lo;
			status_addr: read_byte = status_byte;
			en_lo_addr: read_byte = rail_en.halves.lo;
			en_hi_addr: read_byte = rail_en.halves.hi;
			pg_lo_addr: read_byte = pg_sync.halves.lo;
			pg_hi_addr: read_byte = pg_sync.halves.hi;
			vendor_addr: read_byte = vendor_id0;
			vendor_addr + 8'd1: read_byte = vendor_id1;
			vendor_addr + 8'd2: read_byte = vendor_id2;
			vendor_addr + 8'd3: read_byte = vendor_id3;
			default: read_byte = '0;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			reg_ptr <= '0;
			load_pending <= 1'b0;
			data_to_master <= '0;
			clr_err <= 1'b0;
		end else begin
			load_pending <= data_valid | read_req;
			clr_err <= data_valid && (data_from_master == clr_err_addr);
			// A new address wins over auto-increment
			if (data_valid) begin
				reg_ptr <= data_from_master;
			end else if (read_req) begin
				reg_ptr <= reg_ptr + 8'd1;
			end
			// Byte is sampled once per strobe and held for the master
			if (load_pending) begin
				data_to_master <= read_byte;
			end
		end
	end

	// Snapshot keeps the power-good pattern seen when the fault hit
	always_ff @(posedge clk_in) begin
		if (!fault) begin
			pg_snap <= pg_sync;
		end
	end

	// Reported sysgood implies the whole walk has settled
	assert property (@(posedge clk_in) disable iff (reset) sysgood_raw |-> (&settled));

endmodule

`default_nettype wire

/* logic/power_seq_top.sv */
/*
 * Power-rail sequencer top level
 * Connects input conditioning, timers, sequencer FSM and status registers
 */
`default_nettype none

module power_seq_top #(
	parameter int delay_bits = power_pkg::delay_bits_default,
	parameter int watchdog_bits = power_pkg::watchdog_bits_default
) (
	input wire logic clk_in,
	input wire logic reset,
	input wire logic sysen,
	input wire logic debug_in,
	input wire logic cpub_present_n,
	input wire logic bmc_software_pg,
	input wire logic [power_pkg::rail_count-1:0] rail_pg,
	output logic [power_pkg::rail_count-1:0] rail_en,
	output logic sysgood,
	output logic cpub_clk_oe,
	input wire logic read_req,
	input wire logic data_valid,
	input wire logic [7:0] data_from_master,
	output logic [7:0] data_to_master
);
	import power_pkg::*;

	logic [rail_count-1:0] pg_sync;
	logic [rail_count-1:0] en_req;
	logic [rail_count-1:0] settled;
	logic sysen_sync;
	logic delay_run;
	logic wait_run;
	logic delay_done_pulse;
	logic wait_expired;
	logic fault;
	logic op_err;
	logic wait_err;
	logic sysgood_raw;
	logic clr_err;
	rail_word_u pg_word;
	rail_word_u en_word;

	// Register views of the rail vectors
	assign pg_word.map = '{spare: 1'b0, rails: pg_sync};
	assign en_word.map = '{spare: 1'b0, rails: rail_en};

	rail_conditioner u_conditioner (
		.clk_in(clk_in), .reset(reset), .sysen(sysen), .debug_in(debug_in),
		.cpub_present_n(cpub_present_n), .rail_pg(rail_pg), .en_req(en_req),
		.rail_en(rail_en), .pg_sync(pg_sync), .sysen_sync(sysen_sync),
		.cpub_clk_oe(cpub_clk_oe)
	);

	seq_timer #(.delay_bits(delay_bits), .watchdog_bits(watchdog_bits)) u_timer (
		.clk_in(clk_in), .reset(reset), .delay_run(delay_run), .wait_run(wait_run),
		.delay_done_pulse(delay_done_pulse), .wait_expired(wait_expired)
	);

	sequencer_fsm u_fsm (
		.clk_in(clk_in), .reset(reset), .pg_sync(pg_sync), .sysen_sync(sysen_sync),
		.delay_done_pulse(delay_done_pulse), .wait_expired(wait_expired),
		.clr_err(clr_err), .bmc_software_pg(bmc_software_pg),
		.delay_run(delay_run), .wait_run(wait_run), .en_req(en_req), .settled(settled),
		.fault(fault), .op_err(op_err), .wait_err(wait_err),
		.sysgood_raw(sysgood_raw), .sysgood(sysgood)
	);

	status_regs u_regs (
		.clk_in(clk_in), .reset(reset), .read_req(read_req), .data_valid(data_valid),
		.data_from_master(data_from_master), .pg_sync(pg_word), .rail_en(en_word),
		.settled(settled), .fault(fault), .op_err(op_err), .wait_err(wait_err),
		.sysgood_raw(sysgood_raw), .sysen_sync(sysen_sync),
		.cpub_present_n(cpub_present_n), .data_to_master(data_to_master),
		.clr_err(clr_err)
	);

endmodule

`default_nettype wire

/* dv/power_seq_tb.sv */
/*
 * Power sequencer testbench
 * Rail model with random power-good delays, bus-strobe register reads,
 * fault injection and order checks on the rail enables
 */
`default_nettype none

module power_seq_tb;
	import power_pkg::*;
	import reg_pkg::*;

	localparam int until_sysgood = 0;
	localparam int until_en_off = 1;
	localparam int until_pg_off = 2;
	localparam int wait_limit = 2000;
	localparam int poll_limit = 400;

	logic clk_in = 1'b0;
	logic reset;
	logic sysen;
	logic debug_in;
	logic cpub_present_n;
	logic bmc_software_pg;
	logic [rail_count-1:0] rail_pg;
	logic [rail_count-1:0] rail_en;
	logic sysgood;
	logic cpub_clk_oe;
	logic read_req;
	logic data_valid;
	logic [7:0] data_from_master;
	logic [7:0] data_to_master;

	logic [31:0] rng_state = 32'h3d26_c66d;
	int pg_delay [rail_count];
	int hold_rail = -1;
	int drop_rail = -1;
	logic orderly_down = 1'b0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int errors_at_start = 0;

	// Second-socket rails report good inside the DUT while that CPU is absent
	logic [rail_count-1:0] absent_pg;
	assign absent_pg = cpub_rail_mask & {rail_count{cpub_present_n}};

	power_seq_top #(.delay_bits(4), .watchdog_bits(7)) dut (
		.clk_in(clk_in), .reset(reset), .sysen(sysen), .debug_in(debug_in),
		.cpub_present_n(cpub_present_n), .bmc_software_pg(bmc_software_pg),
		.rail_pg(rail_pg), .rail_en(rail_en), .sysgood(sysgood),
		.cpub_clk_oe(cpub_clk_oe), .read_req(read_req), .data_valid(data_valid),
		.data_from_master(data_from_master), .data_to_master(data_to_master)
	);

	always #50 clk_in = ~clk_in;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Rail model: each power-good follows its enable after 1 to 8 cycles
	always @(posedge clk_in) begin
		logic want;
		#5;
		for (int i = 0; i < rail_count; i++) begin
			want = rail_en[i] && (i != hold_rail) && (i != drop_rail);
			if (want == rail_pg[i]) begin
				pg_delay[i] = 0;
			end else if (pg_delay[i] == 0) begin
				rng_state = xorshift32(rng_state);
				pg_delay[i] = 1 + int'(rng_state % 8);
			end else if (pg_delay[i] == 1) begin
				rail_pg[i] = want;
				pg_delay[i] = 0;
			end else begin
				pg_delay[i] = pg_delay[i] - 1;
			end
		end
	end

	// Up order: a rail turns on only behind a good rail below it
	for (genvar i = 1; i < rail_count; i++) begin : g_up_order
		assert property (@(posedge clk_in) disable iff (reset)
			$rose(rail_en[i]) |-> (rail_pg[i-1] || absent_pg[i-1]))
		else begin
			errors++;
			$display("%0t: rail %0d enabled before rail %0d was good", $time, i, i - 1);
		end
	end

	// Down order: a rail turns off only once the rail above has lost power-good
	for (genvar i = 0; i < rail_count - 1; i++) begin : g_down_order
		assert property (@(posedge clk_in) disable iff (reset || !orderly_down)
			$fell(rail_en[i]) |-> !rail_pg[i+1])
		else begin
			errors++;
			$display("%0t: rail %0d disabled while rail %0d was still good", $time, i, i + 1);
		end
	end

	assert property (@(posedge clk_in) disable iff (reset)
		$rose(sysgood) |-> ($past(bmc_software_pg) && ((rail_pg | absent_pg) == '1)))
	else begin
		errors++;
		$display("%0t: sysgood rose without all rails good and BMC good", $time);
	end

	assert property (@(posedge clk_in) disable iff (reset)
		cpub_present_n |=> (((rail_en & cpub_rail_mask) == '0) && !cpub_clk_oe))
	else begin
		errors++;
		$display("%0t: second-socket rail or clock enabled with the CPU absent", $time);
	end

	task automatic next_cycle();
		@(posedge clk_in);
		#5;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("%0t: timed out waiting for %s", $time, what);
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors + 1);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
			input string name);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Byte is valid from the second edge after the strobe
	task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
		data_from_master = addr;
		data_valid = 1'b1;
		next_cycle();
		data_valid = 1'b0;
		next_cycle();
		data = data_to_master;
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [7:0] exp,
			input string name);
		logic [7:0] data;
		bus_read(addr, data);
		check_value(data, exp, name);
	endtask

	task automatic check_next(input logic [7:0] exp, input string name);
		read_req = 1'b1;
		next_cycle();
		read_req = 1'b0;
		next_cycle();
		check_value(data_to_master, exp, name);
	endtask

	function automatic logic cond_met(input int which);
		case (which)
			until_sysgood: return sysgood;
			until_en_off: return rail_en == '0;
			default: return rail_pg == '0;
		endcase
	endfunction

	task automatic wait_for(input int which, input string what);
		int cycles;
		cycles = 0;
		while (!cond_met(which) && cycles < wait_limit) begin
			next_cycle();
			cycles++;
		end
		if (!cond_met(which)) begin
			abort_on_timeout(what);
		end
	endtask

	task automatic poll_status(input int bit_pos, input string what);
		logic [7:0] data;
		int polls;
		polls = 0;
		data = '0;
		while (!data[bit_pos] && polls < poll_limit) begin
			bus_read(status_addr, data);
			polls++;
		end
		if (!data[bit_pos]) begin
			abort_on_timeout(what);
		end
	endtask

	// Synchronized power-good trails the pins by three edges
	task automatic wait_pg_regs_clear();
		logic [7:0] lo;
		logic [7:0] hi;
		int polls;
		polls = 0;
		lo = 8'hff;
		hi = 8'hff;
		while ((lo != 8'h00 || hi != 8'h00) && polls < poll_limit) begin
			bus_read(pg_lo_addr, lo);
			bus_read(pg_hi_addr, hi);
			polls++;
		end
		if (lo != 8'h00 || hi != 8'h00) begin
			abort_on_timeout("synchronized power-good to clear");
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("Test %0d %s: pass", tests_run, name);
		end else begin
			$display("Test %0d %s: FAIL, %0d errors", tests_run, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	initial begin
		reset = 1'b1;
		sysen = 1'b0;
		debug_in = 1'b1;
		cpub_present_n = 1'b0;
		bmc_software_pg = 1'b0;
		rail_pg = '0;
		read_req = 1'b0;
		data_valid = 1'b0;
		data_from_master = '0;
		repeat (10) @(posedge clk_in);
		#5;
		reset = 1'b0;
		next_cycle();

		// Walk completes, but sysgood waits for the BMC
		sysen = 1'b1;
		poll_status(stat_sysgood_bit, "sequence to complete");
		check_value(sysgood, 1'b0, "sysgood before BMC good");
		bmc_software_pg = 1'b1;
		wait_for(until_sysgood, "sysgood");
		check_value(rail_en, 15'h7fff, "rail_en");
		check_value(cpub_clk_oe, 1'b1, "cpub_clk_oe with CPU present");
		check_read(status_addr, 8'h23, "status on");
		finish_test("power-up order");

		check_read(version_addr, 8'h06, "version");
		check_read(vendor_addr, 8'h52, "vendor byte 0");
		check_next(8'h43, "vendor byte 1");
		check_next(8'h53, "vendor byte 2");
		check_next(8'h20, "vendor byte 3");
		check_read(en_lo_addr, 8'hff, "enable low byte");
		check_read(en_hi_addr, 8'h7f, "enable high byte");
		check_read(pg_lo_addr, 8'hff, "power-good low byte");
		check_read(pg_hi_addr, 8'h7f, "power-good high byte");
		finish_test("register readout");

		orderly_down = 1'b1;
		sysen = 1'b0;
		wait_for(until_pg_off, "rails to power down");
		check_value(rail_en, 15'h0000, "rail_en after power-down");
		check_value(sysgood, 1'b0, "sysgood after power-down");
		check_read(status_addr, 8'h20, "status off");
		orderly_down = 1'b0;
		finish_test("power-down order");

		// Rail 9 never reports good
		hold_rail = 9;
		sysen = 1'b1;
		poll_status(stat_fault_bit, "watchdog fault");
		wait_for(until_en_off, "enables to drop on fault");
		check_read(status_addr, 8'h36, "status after watchdog fault");
		wait_for(until_pg_off, "rails to drop after fault");
		wait_pg_regs_clear();
		hold_rail = -1;
		check_read(clr_err_addr, 8'hff, "error clear");
		wait_for(until_sysgood, "sysgood after watchdog clear");
		check_read(status_addr, 8'h23, "status after restart");
		finish_test("watchdog fault");

		// Rail 6 loses power-good after settling
		drop_rail = 6;
		poll_status(stat_fault_bit, "operation fault");
		wait_for(until_en_off, "enables to drop on fault");
		check_read(status_addr, 8'h2e, "status after operation fault");
		check_read(pg_snap_hi_addr, 8'h7f, "snapshot high byte");
		check_read(pg_snap_lo_addr, 8'hbf, "snapshot low byte");
		wait_for(until_pg_off, "rails to drop after fault");
		wait_pg_regs_clear();
		drop_rail = -1;
		check_read(clr_err_addr, 8'hff, "error clear");
		wait_for(until_sysgood, "sysgood after operation clear");
		finish_test("operation fault");

		orderly_down = 1'b1;
		sysen = 1'b0;
		wait_for(until_pg_off, "rails to power down");
		orderly_down = 1'b0;
		cpub_present_n = 1'b1;
		next_cycle();
		next_cycle();
		check_value(cpub_clk_oe, 1'b0, "cpub_clk_oe");
		sysen = 1'b1;
		wait_for(until_sysgood, "sysgood without second CPU");
		check_value(rail_en, 15'h2ab7, "rail_en without second CPU");
		check_read(status_addr, 8'h03, "status without second CPU");
		finish_test("second socket absent");

		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
logic/power_pkg.sv
logic/reg_pkg.sv
logic/rail_conditioner.sv
logic/seq_timer.sv
logic/sequencer_fsm.sv
logic/status_regs.sv
logic/power_seq_top.sv
dv/power_seq_tb.sv
